//--- gf2_rank_sa.f
+incdir+.
mat_pkg.sv
cell_pkg.sv
row_skewer.sv
elim_cell.sv
elim_array.sv
rank_collector.sv
gf2_rank_sa.sv
gf2_rank_sa_props.sv
gf2_rank_sa_tb.sv

//--- gf2_rank_sa_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module gf2_rank_sa_tb;

  localparam int N        = `SA_N;
  localparam int RST_CYC  = 5;
  localparam int IDLE_CYC = 20;
  localparam int NUM_DIR  = 8;
  localparam int NUM_RAND = 50;
  localparam int SLOT_CYC = N + `SA_LAT + 4;
  localparam int WDOG_CYC = RST_CYC + IDLE_CYC + NUM_DIR * SLOT_CYC + NUM_RAND * N
                            + `SA_LAT + 20;

  logic           clk;
  logic           rst_n;
  logic           start;
  mat_pkg::row_t  row_in;
  logic           finish;
  logic           full_rank;
  mat_pkg::rank_t rank;

  int    cycle_cnt;
  int    err_cnt;
  int    chk_cnt;
  int    exp_rank_q[$];
  logic  exp_full_q[$];
  int    start_cyc_q[$];
  string name_q[$];
  int    held_rank;
  logic  held_full;
  string last_name;

  gf2_rank_sa u_gf2_rank_sa (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .row_in    (row_in),
    .finish    (finish),
    .full_rank (full_rank),
    .rank      (rank)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // row 0 sits in the top nibble of the flat matrix
  function automatic mat_pkg::row_t row_at(input logic [N*N-1:0] mat, input int r);
    return mat[(N-1-r)*N +: N];
  endfunction

  // plain gaussian elimination over gf(2)
  function automatic int rank_of(input logic [N*N-1:0] mat);
    logic [N-1:0] rows [N];
    logic [N-1:0] tmp;
    int           r;
    int           p;
    r = 0;
    for (int i = 0; i < N; i++) begin
      rows[i] = row_at(mat, i);
    end
    for (int c = N - 1; c >= 0; c--) begin
      p = -1;
      for (int i = r; i < N; i++) begin
        if (p < 0 && rows[i][c]) begin
          p = i;
        end
      end
      if (p >= 0) begin
        tmp     = rows[p];
        rows[p] = rows[r];
        rows[r] = tmp;
        for (int i = 0; i < N; i++) begin
          if (i != r && rows[i][c]) begin
            rows[i] = rows[i] ^ rows[r];
          end
        end
        r++;
      end
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_matrix(input logic [N*N-1:0] mat, input string name);
    int exp_r;
    exp_r = rank_of(mat);
    for (int r = 0; r < N; r++) begin
      @(posedge clk);
      #1;
      start  = (r == 0);
      row_in = row_at(mat, r);
      if (r == 0) begin
        // start is sampled on the next edge
        exp_rank_q.push_back(exp_r);
        exp_full_q.push_back(exp_r == N);
        start_cyc_q.push_back(cycle_cnt + 1);
        name_q.push_back(name);
      end
    end
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    start  = 1'b0;
    row_in = '0;
  endtask

  task automatic wait_results(input int limit, input string name);
    int n;
    n = 0;
    while (exp_rank_q.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_rank_q.size() != 0) begin
      $display("results for %s did not arrive within %0d cycles", name, limit);
      err_cnt++;
    end
  endtask

  task automatic run_directed(input logic [N*N-1:0] mat, input string name);
    run_matrix(mat, name);
    go_idle();
    wait_results(SLOT_CYC, name);
    repeat (2) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      if (finish) begin
        if (exp_rank_q.size() == 0) begin
          $display("finish pulsed with no matrix outstanding at cycle %0d", cycle_cnt);
          err_cnt++;
        end else begin
          if (cycle_cnt - start_cyc_q[0] != `SA_LAT) begin
            $display("[FAIL] %s: latency expected %0d actual %0d", name_q[0], `SA_LAT,
                     cycle_cnt - start_cyc_q[0]);
            err_cnt++;
          end
          if (rank !== mat_pkg::rank_t'(exp_rank_q[0])) begin
            $display("[FAIL] %s: rank expected %0d actual %0d", name_q[0],
                     exp_rank_q[0], rank);
            err_cnt++;
          end
          if (full_rank !== exp_full_q[0]) begin
            $display("[FAIL] %s: full_rank expected %0b actual %0b", name_q[0],
                     exp_full_q[0], full_rank);
            err_cnt++;
          end
          chk_cnt   += 3;
          last_name = name_q[0];
          held_rank = exp_rank_q[0];
          held_full = exp_full_q[0];
          void'(exp_rank_q.pop_front());
          void'(exp_full_q.pop_front());
          void'(start_cyc_q.pop_front());
          void'(name_q.pop_front());
        end
      end else begin
        // outputs hold between finishes
        if (rank !== mat_pkg::rank_t'(held_rank)) begin
          $display("[FAIL] %s: held rank expected %0d actual %0d", last_name, held_rank, rank);
          err_cnt++;
        end
        if (full_rank !== held_full) begin
          $display("[FAIL] %s: held full_rank expected %0b actual %0b", last_name,
                   held_full, full_rank);
          err_cnt++;
        end
        chk_cnt += 2;
        if (exp_rank_q.size() != 0 && cycle_cnt > start_cyc_q[0] + `SA_LAT) begin
          $display("finish for %s did not come at the expected cycle", name_q[0]);
          err_cnt++;
          void'(exp_rank_q.pop_front());
          void'(exp_full_q.pop_front());
          void'(start_cyc_q.pop_front());
          void'(name_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]    rnd;
    logic [N*N-1:0] mat;
    rnd       = $urandom(1);
    clk       = 1'b0;
    rst_n     = 1'b0;
    start     = 1'b0;
    row_in    = '0;
    cycle_cnt = 0;
    err_cnt   = 0;
    chk_cnt   = 0;
    held_rank = 0;
    held_full = 1'b0;
    last_name = "reset_idle";
    repeat (RST_CYC) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // no start, nothing should come out
    repeat (IDLE_CYC) @(posedge clk);
    if (rank !== '0) begin
      $display("[FAIL] reset_idle: rank expected 0 actual %0d", rank);
      err_cnt++;
    end
    chk_cnt++;

    run_directed(16'h8421, "identity");
    run_directed(16'h2814, "permuted_identity");
    run_directed(16'h0000, "all_zero");
    run_directed(16'hAA55, "repeated_rows");
    run_directed(16'h96F3, "xor_of_two_rows");
    run_directed(16'hCCCC, "one_row_four_times");
    run_directed(16'hF731, "upper_triangular");
    run_directed(16'h8CEF, "lower_triangular");

    // back to back, one start every N cycles
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd = $urandom;
      mat = rnd[N*N-1:0];
      if (i % 3 == 0) begin
        mat[0 +: N] = mat[(N-1)*N +: N] ^ mat[(N-2)*N +: N];
      end
      run_matrix(mat, $sformatf("random_%0d", i));
    end
    go_idle();
    wait_results(`SA_LAT + 10, "random batch");
    repeat (4) @(posedge clk);

    $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, checks: %0d errors: %0d", WDOG_CYC,
             chk_cnt, err_cnt);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- gf2_rank_sa_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module gf2_rank_sa_props (
  input logic           clk,
  input logic           rst_n,
  input logic           start,
  input logic           finish,
  input logic           full_rank,
  input mat_pkg::rank_t rank
);

  // synchronous reset clears the finish register
  finish_low_after_reset: assert property (
    @(posedge clk) !rst_n |=> !finish
  ) else $error("finish high after a reset cycle");

  // finish updates on edge SA_LAT, seen one edge later
  finish_after_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    start |-> ##(`SA_LAT + 1) finish
  ) else $error("finish missing %0d cycles after start", `SA_LAT);

  finish_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    finish |=> !finish
  ) else $error("finish high for two cycles in a row");

  full_rank_matches_rank: assert property (
    @(posedge clk) disable iff (!rst_n)
    finish |-> (full_rank == (rank == mat_pkg::rank_t'(`SA_N)))
  ) else $error("full_rank disagrees with rank %0d", rank);

endmodule

bind gf2_rank_sa gf2_rank_sa_props u_gf2_rank_sa_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .start     (start),
  .finish    (finish),
  .full_rank (full_rank),
  .rank      (rank)
);

`default_nettype wire

//--- gf2_rank_sa.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module gf2_rank_sa (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  mat_pkg::row_t  row_in,
  output logic           finish,
  output logic           full_rank,
  output mat_pkg::rank_t rank
);

  logic [`SA_N-1:0]    col_bit;
  logic                first_tok;
  logic                last_tok;
  mat_pkg::pivot_vec_t row_pivot;
  logic [`SA_N-1:0]    row_done;

  // parallel rows into skewed columns
  row_skewer u_row_skewer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .row_in    (row_in),
    .col_bit   (col_bit),
    .first_tok (first_tok),
    .last_tok  (last_tok)
  );

  elim_array u_elim_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_bit   (col_bit),
    .first_tok (first_tok),
    .last_tok  (last_tok),
    .row_pivot (row_pivot),
    .row_done  (row_done)
  );

  // pivot count per matrix
  rank_collector u_rank_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .row_pivot (row_pivot),
    .row_done  (row_done),
    .finish    (finish),
    .full_rank (full_rank),
    .rank      (rank)
  );

endmodule

`default_nettype wire

//--- rank_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module rank_collector (
  input  logic                clk,
  input  logic                rst_n,
  input  mat_pkg::pivot_vec_t row_pivot,
  input  logic [`SA_N-1:0]    row_done,
  output logic                finish,
  output logic                full_rank,
  output mat_pkg::rank_t      rank
);

  localparam int N = `SA_N;

  mat_pkg::pivot_vec_t aligned;
  mat_pkg::rank_t      pop_cnt;

  // row k finishes N-1-k cycles ahead of the bottom row
  for (genvar k = 0; k < N; k++) begin : g_align
    localparam int DEPTH = N - 1 - k;

    if (DEPTH == 0) begin : g_direct
      assign aligned[k] = row_pivot[k] & row_done[k];
    end else begin : g_delay
      logic [DEPTH-1:0] dly;

      always_ff @(posedge clk) begin
        dly[0] <= row_pivot[k] & row_done[k];
        for (int i = 1; i < DEPTH; i++) begin
          dly[i] <= dly[i-1];
        end
      end

      assign aligned[k] = dly[DEPTH-1];
    end
  end

  always_comb begin
    pop_cnt = '0;
    for (int k = 0; k < N; k++) begin
      pop_cnt = pop_cnt + mat_pkg::rank_t'(aligned[k]);
    end
  end

  // results hold until the next matrix finishes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      finish    <= 1'b0;
      full_rank <= 1'b0;
      rank      <= '0;
    end else begin
      finish <= row_done[N-1];
      if (row_done[N-1]) begin
        rank      <= pop_cnt;
        full_rank <= (pop_cnt == mat_pkg::rank_t'(N));
      end
    end
  end

endmodule

`default_nettype wire

//--- elim_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module elim_array (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`SA_N-1:0]    col_bit,
  input  logic                first_tok,
  input  logic                last_tok,
  output mat_pkg::pivot_vec_t row_pivot,
  output logic [`SA_N-1:0]    row_done
);

  localparam int N = `SA_N;

  // registers behind every cell
  logic             bit_q   [N][N];
  cell_pkg::sweep_e sweep_q [N][N];
  logic             first_q [N][N];
  logic             last_q  [N][N];
  logic             acc_q   [N][N];

  for (genvar k = 0; k < N; k++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      logic             bit_i;
      logic             first_i;
      logic             last_i;
      logic             acc_i;
      cell_pkg::sweep_e sweep_i;
      logic             bit_o;
      logic             first_o;
      logic             last_o;
      logic             piv_o;
      cell_pkg::sweep_e sweep_o;

      ////////////////////////////////////////////////////////////////////////
      // inputs from above and from the left
      ////////////////////////////////////////////////////////////////////////

      if (k == 0) begin : g_top
        assign bit_i = col_bit[j];
      end else begin : g_below
        assign bit_i = bit_q[k-1][j];
      end

      if (j == 0) begin : g_left
        assign sweep_i = cell_pkg::sweep_none;
        assign acc_i   = 1'b0;
        if (k == 0) begin : g_entry
          assign first_i = first_tok;
          assign last_i  = last_tok;
        end else begin : g_down
          assign first_i = first_q[k-1][0];
          assign last_i  = last_q[k-1][0];
        end
      end else begin : g_inner
        assign sweep_i = sweep_q[k][j-1];
        assign acc_i   = acc_q[k][j-1];
        assign first_i = first_q[k][j-1];
        assign last_i  = last_q[k][j-1];
      end

      elim_cell u_cell (
        .clk       (clk),
        .rst_n     (rst_n),
        .bit_in    (bit_i),
        .first_in  (first_i),
        .last_in   (last_i),
        .sweep_in  (sweep_i),
        .bit_out   (bit_o),
        .first_out (first_o),
        .last_out  (last_o),
        .sweep_out (sweep_o),
        .has_pivot (piv_o)
      );

      ////////////////////////////////////////////////////////////////////////
      // pipeline registers
      ////////////////////////////////////////////////////////////////////////

      if (k < N - 1) begin : g_bit_reg
        always_ff @(posedge clk) begin
          bit_q[k][j] <= bit_o;
        end
      end

      if (j < N - 1) begin : g_right_reg
        always_ff @(posedge clk) begin
          if (!rst_n) begin
            sweep_q[k][j] <= cell_pkg::sweep_none;
            first_q[k][j] <= 1'b0;
          end else begin
            sweep_q[k][j] <= sweep_o;
            first_q[k][j] <= first_o;
          end
        end
      end

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          last_q[k][j] <= 1'b0;
        end else begin
          last_q[k][j] <= last_o;
        end
      end

      // row pivot flag built up alongside the last-row token
      always_ff @(posedge clk) begin
        acc_q[k][j] <= acc_i | piv_o;
      end
    end

    assign row_pivot[k] = acc_q[k][N-1];
    assign row_done[k]  = last_q[k][N-1];
  end

endmodule

`default_nettype wire

//--- elim_cell.sv
`timescale 1ns/1ps
`default_nettype none

module elim_cell (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             bit_in,
  input  logic             first_in,
  input  logic             last_in,
  input  cell_pkg::sweep_e sweep_in,
  output logic             bit_out,
  output logic             first_out,
  output logic             last_out,
  output cell_pkg::sweep_e sweep_out,
  output logic             has_pivot
);

  cell_pkg::cell_state_e state_q;
  cell_pkg::cell_state_e state_d;
  cell_pkg::cell_state_e state_cur;
  logic                  bit_q;
  logic                  bit_d;
  logic                  bit_cur;

  ////////////////////////////////////////////////////////////////////////////
  // decision
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // a new matrix wipes the old pivot first
    state_cur = first_in ? cell_pkg::cell_empty : state_q;
    bit_cur   = (state_cur == cell_pkg::cell_empty) ? 1'b0 : bit_q;

    state_d   = state_cur;
    bit_d     = bit_cur;
    bit_out   = bit_in;
    sweep_out = cell_pkg::sweep_none;

    case (sweep_in)
      cell_pkg::sweep_capture: begin
        // old pivot bit goes down, so an earlier lead swaps it out
        state_d   = cell_pkg::cell_captured;
        bit_d     = bit_in;
        bit_out   = bit_cur;
        sweep_out = cell_pkg::sweep_capture;
      end
      cell_pkg::sweep_reduce: begin
        bit_out   = bit_in ^ bit_cur;
        sweep_out = cell_pkg::sweep_reduce;
      end
      default: begin
        if (bit_in && state_cur == cell_pkg::cell_empty) begin
          state_d   = cell_pkg::cell_leading;
          bit_d     = 1'b1;
          bit_out   = bit_cur;
          sweep_out = cell_pkg::sweep_capture;
        end else if (bit_in && state_cur == cell_pkg::cell_leading) begin
          bit_out   = bit_in ^ bit_cur;
          sweep_out = cell_pkg::sweep_reduce;
        end
      end
    endcase
  end

  // tokens just ride along
  assign first_out = first_in;
  assign last_out  = last_in;

  // includes a capture made this cycle
  assign has_pivot = (state_d == cell_pkg::cell_leading);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= cell_pkg::cell_empty;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    bit_q <= bit_d;
  end

endmodule

`default_nettype wire

//--- row_skewer.sv
`timescale 1ns/1ps
`default_nettype none

`include "gf2_defs.svh"

module row_skewer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  mat_pkg::row_t       row_in,
  output logic [`SA_N-1:0]    col_bit,
  output logic                first_tok,
  output logic                last_tok
);

  localparam int N     = `SA_N;
  localparam int CNT_W = $clog2(N);

  logic [CNT_W-1:0] row_cnt;

  // column j leaves after j+1 registers, col_bit[j] is column j
  for (genvar j = 0; j < N; j++) begin : g_col
    logic [j:0] dly;

    always_ff @(posedge clk) begin
      dly[0] <= row_in[N-1-j];
      for (int i = 1; i <= j; i++) begin
        dly[i] <= dly[i-1];
      end
    end

    assign col_bit[j] = dly[j];
  end

  // tokens line up with column 0 of row 0 and of row N-1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt   <= '0;
      first_tok <= 1'b0;
      last_tok  <= 1'b0;
    end else begin
      first_tok <= start;
      last_tok  <= (row_cnt == CNT_W'(1));
      if (start) begin
        row_cnt <= CNT_W'(N - 1);
      end else if (row_cnt != '0) begin
        row_cnt <= row_cnt - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- cell_pkg.sv
`default_nettype none

package cell_pkg;

  // leading marks the column where the row pivot has its first 1
  typedef enum logic [1:0] {
    cell_empty    = 2'd0,
    cell_captured = 2'd1,
    cell_leading  = 2'd2
  } cell_state_e;

  // decision passed to the right along an array row
  typedef enum logic [1:0] {
    sweep_none    = 2'd0,
    sweep_capture = 2'd1,
    sweep_reduce  = 2'd2
  } sweep_e;

endpackage

`default_nettype wire

//--- mat_pkg.sv
`default_nettype none

`include "gf2_defs.svh"

package mat_pkg;

  // one matrix row, bit N-1 is column 0
  typedef logic [`SA_N-1:0] row_t;

  // number of pivots found
  typedef logic [`SA_RANK_W-1:0] rank_t;

  // one flag per array row
  typedef logic [`SA_N-1:0] pivot_vec_t;

endpackage

`default_nettype wire

//--- gf2_defs.svh
`ifndef GF2_DEFS_SVH
`define GF2_DEFS_SVH

// matrix size, also the array dimension
`define SA_N 4

// edges from the sampled start to the rising finish
`define SA_LAT (3 * `SA_N - 1)

// rank count must hold 0 to SA_N
`define SA_RANK_W 3

`endif
